// ==== source/aes_defines.svh ====
`ifndef AES_DEFINES_SVH
`define AES_DEFINES_SVH

// AES-128 round count
`define AES_ROUNDS 10

`define AES_BLOCK_BITS 128
`define AES_BYTE_BITS 8

// Segments per display digit
`define SEG_WIDTH 7

// Low byte of the field polynomial x^8 + x^4 + x^3 + x + 1
`define AES_GF_POLY 8'h1b

`endif

// ==== source/aesPkg.sv ====
`include "aes_defines.svh"

package aesPkg;

  // Byte 0 is the most significant byte; byte 4c+r is row r of column c
  typedef logic [`AES_BLOCK_BITS-1:0] aesBlock;

  typedef logic [`AES_BYTE_BITS-1:0] aesByte;

  // Round key 1 sits in the most significant slice
  typedef logic [`AES_ROUNDS*`AES_BLOCK_BITS-1:0] roundKeySet;

  typedef logic [$clog2(`AES_ROUNDS+1)-1:0] roundIndex;

  typedef logic [3:0] decimalDigit;

  // Active low
  typedef logic [`SEG_WIDTH-1:0] segPattern;

  typedef struct packed {
    segPattern hundreds;
    segPattern tens;
    segPattern ones;
  } segDisplay;

  typedef enum logic [1:0] {
    phaseLoad,
    phaseRounds,
    phaseDone
  } cipherPhase;

endpackage

// ==== source/byteSubShift.sv ====
`include "aes_defines.svh"

module byteSubShift (
  input  aesPkg::aesBlock stateIn,
  output aesPkg::aesBlock stateOut
);

  localparam int byteBits = `AES_BYTE_BITS;
  localparam int blockBytes = `AES_BLOCK_BITS / `AES_BYTE_BITS;
  localparam int rows = 4;
  localparam int cols = blockBytes / rows;

  // Forward S-box with sixteen entries per row and the lowest index leftmost
  localparam aesPkg::aesBlock sboxRows [16] = '{
    128'h637c777bf26b6fc53001672bfed7ab76,
    128'hca82c97dfa5947f0add4a2af9ca472c0,
    128'hb7fd9326363ff7cc34a5e5f171d83115,
    128'h04c723c31896059a071280e2eb27b275,
    128'h09832c1a1b6e5aa0523bd6b329e32f84,
    128'h53d100ed20fcb15b6acbbe394a4c58cf,
    128'hd0efaafb434d338545f9027f503c9fa8,
    128'h51a3408f929d38f5bcb6da2110fff3d2,
    128'hcd0c13ec5f974417c4a77e3d645d1973,
    128'h60814fdc222a908846eeb814de5e0bdb,
    128'he0323a0a4906245cc2d3ac629195e479,
    128'he7c8376d8dd54ea96c56f4ea657aae08,
    128'hba78252e1ca6b4c6e8dd741f4bbd8b8a,
    128'h703eb5664803f60e613557b986c11d9e,
    128'he1f8981169d98e949b1e87e9ce5528df,
    128'h8ca1890dbfe6426841992d0fb054bb16
  };

  function automatic aesPkg::aesByte subByte(input aesPkg::aesByte value);
    aesPkg::aesBlock row;
    row = sboxRows[value[7:4]];
    return row[(15 - value[3:0]) * byteBits +: byteBits];
  endfunction

  always_comb begin
    int dstIdx;
    int srcIdx;
    for (int c = 0; c < cols; c++) begin
      for (int r = 0; r < rows; r++) begin
        dstIdx = rows * c + r;
        // Row r rotates left by r columns
        srcIdx = rows * ((c + r) % cols) + r;
        stateOut[(blockBytes - 1 - dstIdx) * byteBits +: byteBits] =
            subByte(stateIn[(blockBytes - 1 - srcIdx) * byteBits +: byteBits]);
      end
    end
  end

endmodule

// ==== source/mixColumns.sv ====
`include "aes_defines.svh"

module mixColumns (
  input  aesPkg::aesBlock stateIn,
  output aesPkg::aesBlock stateOut
);

  localparam int byteBits = `AES_BYTE_BITS;
  localparam int blockBytes = `AES_BLOCK_BITS / `AES_BYTE_BITS;
  localparam int rows = 4;
  localparam int cols = blockBytes / rows;

  // Multiply by two in GF(2^8)
  function automatic aesPkg::aesByte xtime(input aesPkg::aesByte value);
    return {value[byteBits-2:0], 1'b0} ^ (value[byteBits-1] ? `AES_GF_POLY : 8'h00);
  endfunction

  always_comb begin
    aesPkg::aesByte col [rows];
    aesPkg::aesByte twice [rows];
    for (int c = 0; c < cols; c++) begin
      for (int r = 0; r < rows; r++) begin
        col[r] = stateIn[(blockBytes - 1 - (rows * c + r)) * byteBits +: byteBits];
        twice[r] = xtime(col[r]);
      end
      for (int r = 0; r < rows; r++) begin
        // 2*a[r] ^ 3*a[r+1] ^ a[r+2] ^ a[r+3]
        stateOut[(blockBytes - 1 - (rows * c + r)) * byteBits +: byteBits] =
            twice[r] ^ twice[(r + 1) % rows] ^ col[(r + 1) % rows] ^
            col[(r + 2) % rows] ^ col[(r + 3) % rows];
      end
    end
  end

endmodule

// ==== source/cipherRound.sv ====
module cipherRound (
  input  aesPkg::aesBlock roundIn,
  input  aesPkg::aesBlock roundKey,
  output aesPkg::aesBlock roundOut
);

  aesPkg::aesBlock substituted;
  aesPkg::aesBlock mixed;

  byteSubShift subShift (
    .stateIn (roundIn),
    .stateOut(substituted)
  );

  mixColumns mix (
    .stateIn (substituted),
    .stateOut(mixed)
  );

  // AddRoundKey closes the round
  assign roundOut = mixed ^ roundKey;

endmodule

// ==== source/segmentDisplay.sv ====
`include "aes_defines.svh"

module segmentDisplay (
  input  aesPkg::aesByte value,
  output aesPkg::segDisplay display
);

  aesPkg::decimalDigit hundreds;
  aesPkg::decimalDigit tens;
  aesPkg::decimalDigit ones;

  function automatic aesPkg::segPattern toSegments(input aesPkg::decimalDigit digit);
    case (digit)
      4'd0: return 7'b1000000;
      4'd1: return 7'b1111001;
      4'd2: return 7'b0100100;
      4'd3: return 7'b0110000;
      4'd4: return 7'b0011001;
      4'd5: return 7'b0010010;
      4'd6: return 7'b0000010;
      4'd7: return 7'b1111000;
      4'd8: return 7'b0000000;
      4'd9: return 7'b0010000;
      // Blank
      default: return 7'b1111111;
    endcase
  endfunction

  // Shift-add-3 adds three to digits above four after each of the first seven shifts
  always_comb begin
    logic [11:0] bcd;
    bcd = '0;
    for (int i = 0; i < `AES_BYTE_BITS; i++) begin
      bcd = {bcd[10:0], value[`AES_BYTE_BITS - 1 - i]};
      if (i < `AES_BYTE_BITS - 1) begin
        for (int d = 0; d < 3; d++) begin
          if (bcd[4*d +: 4] > 4'd4) begin
            bcd[4*d +: 4] = bcd[4*d +: 4] + 4'd3;
          end
        end
      end
    end
    hundreds = bcd[11:8];
    tens = bcd[7:4];
    ones = bcd[3:0];
  end

  assign display = '{
    hundreds: toSegments(hundreds),
    tens:     toSegments(tens),
    ones:     toSegments(ones)
  };

  always_comb begin
    assert (hundreds <= 4'd2 && tens <= 4'd9 && ones <= 4'd9)
      else $error("BCD digit out of range for value %0d", value);
  end

endmodule

// ==== source/aesEncrypt.sv ====
`include "aes_defines.svh"

module aesEncrypt (
  input  logic               clk,
  input  logic               reset,
  input  aesPkg::aesBlock    plainText,
  input  aesPkg::aesBlock    cipherKey,
  input  aesPkg::roundKeySet roundKeys,
  output aesPkg::aesBlock    cipherText,
  output aesPkg::segDisplay  display
);

  localparam aesPkg::roundIndex lastMiddleRound = aesPkg::roundIndex'(`AES_ROUNDS - 1);
  localparam int byteBits = `AES_BYTE_BITS;

  aesPkg::cipherPhase phase;
  aesPkg::roundIndex  roundCount;
  aesPkg::aesBlock    stateReg;
  aesPkg::aesBlock    finalStateReg;
  aesPkg::aesBlock    roundKey;
  aesPkg::aesBlock    roundOut;
  aesPkg::aesBlock    finalSubShift;
  aesPkg::aesByte     displayByte;

  // Round key number roundCount out of the packed set
  always_comb begin
    roundKey = '0;
    for (int k = 1; k <= `AES_ROUNDS; k++) begin
      if (roundCount == aesPkg::roundIndex'(k)) begin
        roundKey = roundKeys[(`AES_ROUNDS - k) * `AES_BLOCK_BITS +: `AES_BLOCK_BITS];
      end
    end
  end

  cipherRound middleRound (
    .roundIn (stateReg),
    .roundKey(roundKey),
    .roundOut(roundOut)
  );

  // Final round skips MixColumns
  byteSubShift finalRound (
    .stateIn (finalStateReg),
    .stateOut(finalSubShift)
  );

  assign cipherText = finalSubShift ^ roundKeys[`AES_BLOCK_BITS-1:0];

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      phase <= aesPkg::phaseLoad;
      roundCount <= '0;
      stateReg <= '0;
      finalStateReg <= '0;
    end else begin
      case (phase)
        aesPkg::phaseLoad: begin
          // Initial AddRoundKey with the cipher key
          stateReg <= plainText ^ cipherKey;
          roundCount <= roundCount + 1'b1;
          phase <= aesPkg::phaseRounds;
        end
        aesPkg::phaseRounds: begin
          if (roundCount == lastMiddleRound) begin
            finalStateReg <= roundOut;
            phase <= aesPkg::phaseDone;
          end else begin
            stateReg <= roundOut;
          end
          roundCount <= roundCount + 1'b1;
        end
        aesPkg::phaseDone: begin
          // Hold the result until the next reset
          phase <= aesPkg::phaseDone;
        end
        default: begin
          phase <= aesPkg::phaseLoad;
          roundCount <= '0;
        end
      endcase
    end
  end

  // Last byte of whichever state is current
  always_comb begin
    case (phase)
      aesPkg::phaseLoad:   displayByte = plainText[byteBits-1:0];
      aesPkg::phaseRounds: displayByte = stateReg[byteBits-1:0];
      default:             displayByte = finalStateReg[byteBits-1:0];
    endcase
  end

  segmentDisplay digits (
    .value  (displayByte),
    .display(display)
  );

  assert property (@(posedge clk) disable iff (reset) roundCount <= `AES_ROUNDS)
    else $error("Round count %0d past the last round", roundCount);

  assert property (@(posedge clk) disable iff (reset)
    phase == aesPkg::phaseDone |=> $stable(roundCount) && $stable(finalStateReg))
    else $error("Result changed after completion");

endmodule

// ==== verification/aesEncryptTb.sv ====
`include "aes_defines.svh"

module aesEncryptTb;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int halfPeriod = 2;
  localparam int resetCycles = 8;
  localparam int resetHoldCycles = 2;
  localparam int randomChecks = 20;
  localparam int holdCycles = 5;
  localparam int interruptRuns = 6;
  localparam int edgeTimeout = 8 * halfPeriod;
  localparam int fieldCount = `AES_ROUNDS + 4;
  localparam int blockBytes = `AES_BLOCK_BITS / `AES_BYTE_BITS;
  localparam string casesPath = "verification/aes_cases.txt";

  // Active-low digit patterns indexed by the decimal digit
  localparam aesPkg::segPattern segTable [10] = '{
    7'b1000000, 7'b1111001, 7'b0100100, 7'b0110000, 7'b0011001,
    7'b0010010, 7'b0000010, 7'b1111000, 7'b0000000, 7'b0010000
  };

  logic clk;
  logic reset;
  aesPkg::aesBlock plainText;
  aesPkg::aesBlock cipherKey;
  aesPkg::roundKeySet roundKeys;
  aesPkg::aesBlock cipherText;
  aesPkg::segDisplay display;

  aesPkg::aesBlock casePlain [$];
  aesPkg::aesBlock caseKey [$];
  aesPkg::roundKeySet caseRoundKeys [$];
  aesPkg::aesBlock caseCipher [$];
  aesPkg::aesByte caseFinalByte [$];

  logic [31:0] rngState;
  int edgeCount;
  int edgeTarget;
  bit edgeRising;

  aesEncrypt uut (
    .clk       (clk),
    .reset     (reset),
    .plainText (plainText),
    .cipherKey (cipherKey),
    .roundKeys (roundKeys),
    .cipherText(cipherText),
    .display   (display)
  );

  always #halfPeriod clk = ~clk;

  task automatic stopRun(input string reason);
    $display("%s", reason);
    $display("SIMULATION FAILED");
    $fatal(1, "Stopped at the first error");
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic aesPkg::aesByte randomByte();
    rngState = xorshift32(rngState);
    return rngState[7:0];
  endfunction

  function automatic aesPkg::segPattern digitSegments(input int digit);
    return segTable[digit];
  endfunction

  // Decimal digits of the byte with hundreds in the top field
  function automatic aesPkg::segDisplay expectedDisplay(input aesPkg::aesByte value);
    aesPkg::segDisplay result;
    result.hundreds = digitSegments(int'(value) / 100);
    result.tens = digitSegments((int'(value) / 10) % 10);
    result.ones = digitSegments(int'(value) % 10);
    return result;
  endfunction

  task automatic checkBlock(input string name, input aesPkg::aesBlock expected,
                            input aesPkg::aesBlock actual);
    assert (actual === expected)
      else stopRun($sformatf("FAILED at %0t ns: %s expected %h, actual %h",
                             $time, name, expected, actual));
  endtask

  task automatic checkDisplay(input aesPkg::segDisplay expected,
                              input aesPkg::segDisplay actual);
    assert (actual === expected)
      else stopRun($sformatf("FAILED at %0t ns: display expected %b, actual %b",
                             $time, expected, actual));
  endtask

  // Counts clock edges while a timer branch bounds the wait
  task automatic waitClock(input int count, input bit rising);
    edgeCount = 0;
    edgeTarget = count;
    edgeRising = rising;
    fork
      begin
        while (edgeCount < edgeTarget) begin
          if (edgeRising) begin
            @(posedge clk);
          end else begin
            @(negedge clk);
          end
          edgeCount++;
        end
      end
      begin
        #(edgeTarget * edgeTimeout);
      end
    join_any
    assert (edgeCount >= count)
      else stopRun($sformatf("Timed out after %0d of %0d clock edges", edgeCount, count));
  endtask

  task automatic loadCases();
    int fd;
    int fields;
    string line;
    aesPkg::aesBlock pt;
    aesPkg::aesBlock key;
    aesPkg::aesBlock ct;
    aesPkg::aesBlock rk [`AES_ROUNDS];
    aesPkg::aesByte finalByte;
    aesPkg::roundKeySet keySet;
    fd = $fopen(casesPath, "r");
    assert (fd != 0)
      else stopRun($sformatf("Could not open the cases file %s", casesPath));
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() < 2 || line.getc(0) == "#") begin
        continue;
      end
      fields = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                       pt, key, rk[0], rk[1], rk[2], rk[3], rk[4],
                       rk[5], rk[6], rk[7], rk[8], rk[9], ct, finalByte);
      assert (fields == fieldCount)
        else stopRun($sformatf("Case line has %0d fields instead of %0d", fields, fieldCount));
      keySet = '0;
      for (int k = 0; k < `AES_ROUNDS; k++) begin
        keySet[(`AES_ROUNDS - 1 - k) * `AES_BLOCK_BITS +: `AES_BLOCK_BITS] = rk[k];
      end
      casePlain.push_back(pt);
      caseKey.push_back(key);
      caseRoundKeys.push_back(keySet);
      caseCipher.push_back(ct);
      caseFinalByte.push_back(finalByte);
    end
    $fclose(fd);
    assert (casePlain.size() > 0)
      else stopRun("The cases file holds no cases");
  endtask

  // Random plaintexts while reset holds the core in the load phase
  task automatic checkResetDisplay();
    aesPkg::aesBlock value;
    for (int i = 0; i < randomChecks; i++) begin
      value = '0;
      for (int b = 0; b < blockBytes; b++) begin
        value = {value[`AES_BLOCK_BITS-`AES_BYTE_BITS-1:0], randomByte()};
      end
      plainText = value;
      #1;
      checkDisplay(expectedDisplay(value[`AES_BYTE_BITS-1:0]), display);
      waitClock(1, 1'b0);
    end
  endtask

  // Leaves the core just after reset release and before the first rising edge
  task automatic applyCase(input int idx);
    aesPkg::aesBlock plain;
    plain = casePlain[idx];
    waitClock(1, 1'b0);
    reset = 1'b1;
    plainText = plain;
    cipherKey = caseKey[idx];
    roundKeys = caseRoundKeys[idx];
    waitClock(resetHoldCycles, 1'b0);
    reset = 1'b0;
    #1;
    checkDisplay(expectedDisplay(plain[`AES_BYTE_BITS-1:0]), display);
  endtask

  task automatic runKnownAnswer(input int idx);
    aesPkg::aesBlock plain;
    aesPkg::aesBlock key;
    aesPkg::aesByte firstStateByte;
    plain = casePlain[idx];
    key = caseKey[idx];
    firstStateByte = plain[`AES_BYTE_BITS-1:0] ^ key[`AES_BYTE_BITS-1:0];
    applyCase(idx);
    waitClock(1, 1'b1);
    waitClock(1, 1'b0);
    #1;
    // Round 1 state is the plaintext XOR the cipher key
    checkDisplay(expectedDisplay(firstStateByte), display);
    waitClock(`AES_ROUNDS - 1, 1'b1);
    for (int i = 0; i <= holdCycles; i++) begin
      waitClock(1, 1'b0);
      #1;
      checkBlock("cipherText", caseCipher[idx], cipherText);
      checkDisplay(expectedDisplay(caseFinalByte[idx]), display);
    end
  endtask

  task automatic runInterrupted(input int idx);
    int stopAfter;
    aesPkg::aesBlock plain;
    plain = casePlain[idx];
    stopAfter = int'(randomByte()) % (`AES_ROUNDS - 1) + 1;
    applyCase(idx);
    waitClock(stopAfter, 1'b1);
    waitClock(1, 1'b0);
    reset = 1'b1;
    #1;
    // Asynchronous reset puts the plaintext byte back on the display
    checkDisplay(expectedDisplay(plain[`AES_BYTE_BITS-1:0]), display);
    runKnownAnswer(idx);
  endtask

  initial begin
    clk = 1'b0;
    reset = 1'b1;
    plainText = '0;
    cipherKey = '0;
    roundKeys = '0;
    rngState = 32'd77249;
    edgeCount = 0;
    edgeTarget = 0;
    edgeRising = 1'b0;
    loadCases();
    waitClock(resetCycles, 1'b0);
    checkResetDisplay();
    for (int i = 0; i < casePlain.size(); i++) begin
      runKnownAnswer(i);
    end
    for (int n = 0; n < interruptRuns; n++) begin
      runInterrupted(n % casePlain.size());
    end
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

// ==== verification/aes_cases.txt ====
# Columns: plaintext, key, round keys 1 to 10, ciphertext, last byte of the round 10 input state
# All values in hex; FIPS-197 appendix B, then appendix C.1
3243f6a8885a308d313198a2e0370734 2b7e151628aed2a6abf7158809cf4f3c a0fafe1788542cb123a339392a6c7605 f2c295f27a96b9435935807a7359f67f 3d80477d4716fe3e1e237e446d7a883b ef44a541a8525b7fb671253bdb0bad00 d4d1c6f87c839d87caf2b8bc11f915bc 6d88a37a110b3efddbf98641ca0093fd 4e54f70e5f5fc9f384a64fb24ea6dc4f ead27321b58dbad2312bf5607f8d292f ac7766f319fadc2128d12941575c006e d014f9a8c9ee2589e13f0cc8b6630ca6 3925841d02dc09fbdc118597196a0b32 d2
00112233445566778899aabbccddeeff 000102030405060708090a0b0c0d0e0f d6aa74fdd2af72fadaa678f1d6ab76fe b692cf0b643dbdf1be9bc5006830b3fe b6ff744ed2c2c9bf6c590cbf0469bf41 47f7f7bc95353e03f96c32bcfd058dfd 3caaa3e8a99f9deb50f3af57adf622aa 5e390f7df7a69296a7553dc10aa31f6b 14f9701ae35fe28c440adf4d4ea9c026 47438735a41c65b9e016baf4aebf7ad2 549932d1f08557681093ed9cbe2c974e 13111d7fe3944a17f307a78b4d2b30c5 69c4e0d86a7b0430d8cdb78070b4c55a 89

// ==== project.f ====
+incdir+source
source/aesPkg.sv
source/byteSubShift.sv
source/mixColumns.sv
source/cipherRound.sv
source/segmentDisplay.sv
source/aesEncrypt.sv
verification/aesEncryptTb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module aesEncryptTb -f project.f

if ./obj_dir/VaesEncryptTb | tee /dev/stderr | grep "SIMULATION PASSED" > /dev/null; then
  echo "run.sh: testbench reported success"
  exit 0
fi
echo "run.sh: testbench reported failure"
exit 1
